// File: src/viterbi_pkg.sv
`default_nettype none

package viterbi_pkg;

    // rate 1/2 K=3 convolutional code with generators 7 and 5 octal
    //
    // state index is {s1, s0} where s1 is the most recent input bit and s0 the one before it
    // on a new input bit u the next state is {u, s1} and s1 becomes the older bit
    // the code symbol sent on that transition is {u ^ s1 ^ s0, u ^ s0}
    // predecessors of state {u, a} are {a, 0} and {a, 1}
    // a decision bit of 1 picks {a, 1}

    localparam int NUM_STATES  = 4;
    localparam int STATE_W     = $clog2(NUM_STATES);
    localparam int SYM_W       = 2;
    localparam int BM_W        = 2;    // hamming distance 0..2
    localparam int PM_W        = 6;    // normalized every step
    localparam int PM_INIT_BAD = 16;   // start metric for states other than 0
    localparam int TRACE_DEPTH = 16;   // survivor length, sets decode delay
    localparam int CNT_W       = $clog2(TRACE_DEPTH + 1);

    // distance from the received symbol to each code symbol
    typedef struct packed {
        logic [BM_W-1:0] dist_11;
        logic [BM_W-1:0] dist_10;
        logic [BM_W-1:0] dist_01;
        logic [BM_W-1:0] dist_00;
    } bm_vec_t;

    typedef struct packed {
        logic [NUM_STATES-1:0][PM_W-1:0] pm;   // one metric per state
    } pm_vec_t;

    typedef struct packed {
        logic [NUM_STATES-1:0] sel;   // surviving predecessor per state
    } decision_t;

    // state 0 known at frame start and the others penalized
    localparam pm_vec_t PM_START = {{(NUM_STATES - 1){PM_W'(PM_INIT_BAD)}}, PM_W'(0)};

    // code symbol for input bit u leaving state st
    function automatic logic [SYM_W-1:0] code_sym(input logic u,
                                                  input logic [STATE_W-1:0] st);
        return {u ^ st[1] ^ st[0], u ^ st[0]};
    endfunction

endpackage

`default_nettype wire

// File: src/branch_metric.sv
`timescale 1ns/1ps
`default_nettype none

module branch_metric
    import viterbi_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             i_valid,
    input  wire logic             i_start,
    input  wire logic [SYM_W-1:0] i_sym,
    output bm_vec_t               o_bm,
    output logic                  o_bm_valid,
    output logic                  o_bm_start
);

    bm_vec_t bm_next;

    function automatic logic [BM_W-1:0] hamming(input logic [SYM_W-1:0] a,
                                                 input logic [SYM_W-1:0] b);
        logic [SYM_W-1:0] diff;
        diff = a ^ b;
        return BM_W'($countones(diff));
    endfunction

    always_comb
    begin
        bm_next.dist_00 = hamming(i_sym, 2'b00);
        bm_next.dist_01 = hamming(i_sym, 2'b01);
        bm_next.dist_10 = hamming(i_sym, 2'b10);
        bm_next.dist_11 = hamming(i_sym, 2'b11);
    end

    // distances held between strobes
    always_ff @(posedge clk)
    begin
        if (i_valid)
        begin
            o_bm <= bm_next;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_bm_valid <= 1'b0;
            o_bm_start <= 1'b0;
        end
        else
        begin
            o_bm_valid <= i_valid;              // one cycle pulse
            o_bm_start <= i_valid & i_start;    // start rides with its symbol
        end
    end

endmodule

`default_nettype wire

// File: src/acs_unit.sv
`timescale 1ns/1ps
`default_nettype none

module acs_unit
    import viterbi_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire bm_vec_t             i_bm,
    input  wire logic                i_bm_valid,
    input  wire logic                i_bm_start,
    output decision_t                o_dec,
    output logic                     o_dec_valid,
    output logic                     o_dec_start,
    output logic [STATE_W-1:0]       o_best_state
);

    pm_vec_t                          pm_q;
    pm_vec_t                          pm_base;
    logic [NUM_STATES-1:0][PM_W-1:0]  acs_pm;
    logic [NUM_STATES-1:0][PM_W-1:0]  norm_pm;
    logic [NUM_STATES-1:0]            acs_sel;
    logic [PM_W-1:0]                  min_pm;
    logic [STATE_W-1:0]               best;

    function automatic logic [BM_W-1:0] pick_bm(input bm_vec_t bm,
                                                 input logic [SYM_W-1:0] sym);
        case (sym)
            2'b00:   return bm.dist_00;
            2'b01:   return bm.dist_01;
            2'b10:   return bm.dist_10;
            default: return bm.dist_11;
        endcase
    endfunction

    // a start symbol runs against the initial metrics
    assign pm_base = i_bm_start ? PM_START : pm_q;

    always_comb
    begin
        logic [STATE_W-1:0] st;
        logic [STATE_W-1:0] p0;
        logic [STATE_W-1:0] p1;
        logic [PM_W-1:0]    m0;
        logic [PM_W-1:0]    m1;
        for (int s = 0; s < NUM_STATES; s++)
        begin
            st = STATE_W'(s);
            p0 = {st[0], 1'b0};
            p1 = {st[0], 1'b1};
            m0 = pm_base.pm[p0] + PM_W'(pick_bm(i_bm, code_sym(st[1], p0)));
            m1 = pm_base.pm[p1] + PM_W'(pick_bm(i_bm, code_sym(st[1], p1)));
            acs_sel[s] = (m1 < m0);              // tie keeps lower predecessor
            acs_pm[s]  = (m1 < m0) ? m1 : m0;
        end
    end

    // smallest metric and its state with ties to the lowest index
    always_comb
    begin
        min_pm = acs_pm[0];
        best   = '0;
        for (int s = 1; s < NUM_STATES; s++)
        begin
            if (acs_pm[s] < min_pm)
            begin
                min_pm = acs_pm[s];
                best   = STATE_W'(s);
            end
        end
        for (int s = 0; s < NUM_STATES; s++)
        begin
            norm_pm[s] = acs_pm[s] - min_pm;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pm_q         <= PM_START;
            o_dec        <= '0;
            o_best_state <= '0;
            o_dec_valid  <= 1'b0;
            o_dec_start  <= 1'b0;
        end
        else
        begin
            o_dec_valid <= i_bm_valid;
            o_dec_start <= i_bm_valid & i_bm_start;
            if (i_bm_valid)
            begin
                pm_q.pm      <= norm_pm;
                o_dec.sel    <= acs_sel;
                o_best_state <= best;    // index of the new best metric
            end
        end
    end

endmodule

`default_nettype wire

// File: src/survivor_memory.sv
`timescale 1ns/1ps
`default_nettype none

module survivor_memory
    import viterbi_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire decision_t           i_dec,
    input  wire logic                i_dec_valid,
    input  wire logic                i_dec_start,
    input  wire logic [STATE_W-1:0]  i_best_state,
    output logic                     o_bit,
    output logic                     o_bit_valid
);

    logic [TRACE_DEPTH-1:0] path_q [NUM_STATES];   // newest bit at lsb
    logic [TRACE_DEPTH-1:0] path_n [NUM_STATES];
    logic [CNT_W-1:0]       sym_cnt;
    logic [CNT_W-1:0]       cnt_n;
    logic                   emit;

    // each state inherits the path of its surviving predecessor
    always_comb
    begin
        logic [STATE_W-1:0] st;
        logic [STATE_W-1:0] pred;
        for (int s = 0; s < NUM_STATES; s++)
        begin
            st   = STATE_W'(s);
            pred = {st[0], i_dec.sel[s]};
            if (i_dec_start)
            begin
                path_n[s] = {{(TRACE_DEPTH - 1){1'b0}}, st[1]};    // fresh frame
            end
            else
            begin
                path_n[s] = {path_q[pred][TRACE_DEPTH-2:0], st[1]};
            end
        end
    end

    // symbol count since start saturates at the window length
    always_comb
    begin
        if (i_dec_start)
        begin
            cnt_n = CNT_W'(1);
        end
        else if (sym_cnt == CNT_W'(TRACE_DEPTH))
        begin
            cnt_n = sym_cnt;
        end
        else
        begin
            cnt_n = sym_cnt + CNT_W'(1);
        end
    end

    assign emit = i_dec_valid && (cnt_n == CNT_W'(TRACE_DEPTH));

    always_ff @(posedge clk)
    begin
        if (i_dec_valid)
        begin
            for (int s = 0; s < NUM_STATES; s++)
            begin
                path_q[s] <= path_n[s];
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sym_cnt     <= '0;
            o_bit_valid <= 1'b0;
            o_bit       <= 1'b0;
        end
        else
        begin
            o_bit_valid <= emit;
            if (i_dec_valid)
            begin
                sym_cnt <= cnt_n;
            end
            if (emit)
            begin
                o_bit <= path_n[i_best_state][TRACE_DEPTH-1];    // oldest bit of best path
            end
        end
    end

endmodule

`default_nettype wire

// File: src/viterbi_top.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_top
    import viterbi_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             i_valid,
    input  wire logic             i_start,
    input  wire logic [SYM_W-1:0] i_sym,
    output logic                  o_bit,
    output logic                  o_bit_valid
);

    bm_vec_t            bm;
    logic               bm_valid;
    logic               bm_start;
    decision_t          dec;
    logic               dec_valid;
    logic               dec_start;
    logic [STATE_W-1:0] best_state;

    branch_metric branch_metric_inst (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_start    (i_start),
        .i_sym      (i_sym),
        .o_bm       (bm),
        .o_bm_valid (bm_valid),
        .o_bm_start (bm_start)
    );

    acs_unit acs_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .i_bm         (bm),
        .i_bm_valid   (bm_valid),
        .i_bm_start   (bm_start),
        .o_dec        (dec),
        .o_dec_valid  (dec_valid),
        .o_dec_start  (dec_start),
        .o_best_state (best_state)
    );

    // decoded bit three cycles after its symbol
    survivor_memory survivor_memory_inst (
        .clk          (clk),
        .rst          (rst),
        .i_dec        (dec),
        .i_dec_valid  (dec_valid),
        .i_dec_start  (dec_start),
        .i_best_state (best_state),
        .o_bit        (o_bit),
        .o_bit_valid  (o_bit_valid)
    );

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import viterbi_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   i_sym_valid,
    input  wire logic   i_sym_start,
    input  wire logic   i_exp_valid,
    input  wire logic   i_exp_bit,
    input  wire logic   i_bit,
    input  wire logic   i_bit_valid,
    output int unsigned o_checked,
    output int unsigned o_mismatch,
    output int unsigned o_missing,
    output int unsigned o_extra,
    output int unsigned o_pending
);

    localparam int LATENCY = 3;    // symbol in to decoded bit out

    logic        exp_q [$];    // expected bits in output order
    int unsigned due_q [$];    // cycles on which an output must appear
    int unsigned cycle;
    int unsigned sym_idx;      // position within the frame counted from 1
    logic        exp_now;

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            exp_q.delete();
            due_q.delete();
            cycle      = 0;
            sym_idx    = 0;
            o_checked  = 0;
            o_mismatch = 0;
            o_missing  = 0;
            o_extra    = 0;
            o_pending  = 0;
        end
        else
        begin
            if (due_q.size() != 0 && due_q[0] == cycle)
            begin
                void'(due_q.pop_front());
                if (!i_bit_valid)
                begin
                    o_missing++;
                    $display("missing decoded bit: nothing came out at %0d ns", $time);
                    if (exp_q.size() != 0)
                    begin
                        void'(exp_q.pop_front());    // keep later bits aligned
                    end
                end
                else if (exp_q.size() == 0)
                begin
                    o_extra++;
                    $display("decoded bit at %0d ns has no expected value left", $time);
                end
                else
                begin
                    exp_now = exp_q.pop_front();
                    o_checked++;
                    if (i_bit !== exp_now)
                    begin
                        o_mismatch++;
                        $display("[FAIL] %0d ns: decoded bit expected %0b, got %0b",
                                 $time, exp_now, i_bit);
                    end
                end
            end
            else if (i_bit_valid)
            begin
                o_extra++;
                $display("unexpected decoded bit at %0d ns, no symbol was due", $time);
            end

            if (i_exp_valid)
            begin
                exp_q.push_back(i_exp_bit);
            end
            if (i_sym_valid)
            begin
                sym_idx = i_sym_start ? 1 : sym_idx + 1;
                if (sym_idx >= TRACE_DEPTH)
                begin
                    due_q.push_back(cycle + LATENCY);    // window is open
                end
            end
            cycle++;
            o_pending = due_q.size();
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_viterbi_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_viterbi_top
    import viterbi_pkg::*;
();

    localparam int CLK_HALF  = 4;
    localparam int MEM_DEPTH = 256;
    localparam int GAP_MAX   = 3;

    logic             clk;
    logic             rst;
    logic             sym_valid;
    logic             sym_start;
    logic [SYM_W-1:0] sym;
    logic             dec_bit;
    logic             dec_bit_valid;
    logic             exp_valid;    // expected bit travels with its symbol
    logic             exp_bit;

    logic [7:0]       stim_mem [MEM_DEPTH];
    int unsigned      cycle_cnt = 0;
    int unsigned      cycle_limit;
    int unsigned      checked_cnt;
    int unsigned      mismatch_cnt;
    int unsigned      missing_cnt;
    int unsigned      extra_cnt;
    int unsigned      pending_cnt;

    viterbi_top viterbi_top_inst (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (sym_valid),
        .i_start     (sym_start),
        .i_sym       (sym),
        .o_bit       (dec_bit),
        .o_bit_valid (dec_bit_valid)
    );

    tb_checker tb_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .i_sym_valid (sym_valid),
        .i_sym_start (sym_start),
        .i_exp_valid (exp_valid),
        .i_exp_bit   (exp_bit),
        .i_bit       (dec_bit),
        .i_bit_valid (dec_bit_valid),
        .o_checked   (checked_cnt),
        .o_mismatch  (mismatch_cnt),
        .o_missing   (missing_cnt),
        .o_extra     (extra_cnt),
        .o_pending   (pending_cnt)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // sums the frame headers up to the zero count at the end of the file
    function automatic int count_symbols();
        int idx;
        int total;
        idx   = 0;
        total = 0;
        while (stim_mem[idx] != 8'h00)
        begin
            total = total + int'(stim_mem[idx]);
            idx   = idx + 1 + 2 * int'(stim_mem[idx]);
        end
        return total;
    endfunction

    task automatic send_symbol(input logic [SYM_W-1:0] s, input logic first,
                               input logic push, input logic b);
        sym_valid = 1'b1;
        sym_start = first;
        sym       = s;
        exp_valid = push;
        exp_bit   = b;
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        sym_valid = 1'b0;
        sym_start = 1'b0;
        exp_valid = 1'b0;
        sym       = SYM_W'($urandom);    // junk on the bus while idle
        repeat (n) @(negedge clk);
    endtask

    initial
    begin
        int idx;
        int n;
        int frame;
        rst       = 1'b0;
        sym_valid = 1'b0;
        sym_start = 1'b0;
        sym       = '0;
        exp_valid = 1'b0;
        exp_bit   = 1'b0;
        void'($urandom(32'hdfb2_6f66));
        $readmemh("tb/viterbi_input.txt", stim_mem);
        cycle_limit = count_symbols() * 4 + 100;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        idle_cycles(6);    // quiet window right after reset

        idx   = 0;
        frame = 0;
        while (stim_mem[idx] != 8'h00)
        begin
            n   = int'(stim_mem[idx]);
            idx = idx + 1;
            for (int k = 0; k < n; k++)
            begin
                send_symbol(stim_mem[idx][SYM_W-1:0], k == 0, k < n - TRACE_DEPTH + 1,
                            stim_mem[idx + 1][0]);
                idx = idx + 2;
                if (frame > 0)
                begin
                    idle_cycles(int'($urandom % (GAP_MAX + 1)));    // first frame back to back
                end
            end
            frame = frame + 1;
        end
        idle_cycles(1);

        while (pending_cnt != 0)
        begin
            @(negedge clk);
        end
        idle_cycles(4);    // catch stray outputs

        $display("checked %0d bits: %0d mismatches, %0d missing, %0d extra",
                 checked_cnt, mismatch_cnt, missing_cnt, extra_cnt);
        if (mismatch_cnt + missing_cnt + extra_cnt == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/viterbi_input.txt
// frame header: symbol count (hex); a count of 0 ends the file
// then per symbol: received symbol (hex, 2 bits) and encoder input bit
20
3 1 2 0 0 1 1 1 1 0 3 0 3 1 2 0
0 1 1 1 2 1 1 0 3 0 3 1 2 0 0 1
2 0 3 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// single bit errors at symbols 3, 11, 19 and 27
28
0 0 3 1 3 1 1 0 0 1 2 0 3 0 0 0
3 1 1 1 0 0 0 1 1 1 2 1 1 0 3 0
3 1 2 0 2 1 2 0 3 0 3 1 1 1 1 0
3 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// short frame, errors at symbols 5 and 14
18
3 1 1 1 1 0 3 0 2 1 1 1 2 1 2 1
1 0 3 0 0 0 0 0 0 0 1 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0

// File: compile.f
src/viterbi_pkg.sv
src/branch_metric.sv
src/acs_unit.sv
src/survivor_memory.sv
src/viterbi_top.sv
tb/tb_checker.sv
tb/tb_viterbi_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the viterbi testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_viterbi_top \
    -Mdir obj_dir -o tb_viterbi_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_viterbi_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1
